// ==== filelist.f ====
logic/trig_word_pkg.sv
logic/trig_event_pkg.sv
logic/trig_chan_former.sv
logic/trig_write_sequencer.sv
logic/trig_delay_mem.sv
logic/trig_decision.sv
logic/trig_event_fifo.sv
logic/trig_process_top.sv
tests/tb_trig_process.sv

// ==== Bender.yml ====
package:
  name: trig_process

sources:
  # packages first, the RTL files use them by scoped names
  - logic/trig_word_pkg.sv
  - logic/trig_event_pkg.sv
  - logic/trig_chan_former.sv
  - logic/trig_write_sequencer.sv
  - logic/trig_delay_mem.sv
  - logic/trig_decision.sv
  - logic/trig_event_fifo.sv
  - logic/trig_process_top.sv
  - target: test
    files:
      - tests/tb_trig_process.sv

// ==== tests/tb_trig_process.sv ====
`timescale 1ns/1ps

module tb_trig_process;

    localparam int NCHAN      = 8;
    localparam int FIFO_DEPTH = 16;
    localparam int WB         = trig_word_pkg::WORD_BITS;
    localparam int AB         = trig_word_pkg::ADDR_BITS;

    // run configuration, latched by the DUT during reset
    localparam int LATENCY  = 40;
    localparam int OFFSET   = 5;
    localparam int HOLDOFF  = 6;
    localparam int PRESCALE = 2;
    // widest address lag that still reaches the memory before its readout
    localparam int LAG_MAX  = LATENCY - (NCHAN + 4);
    // cycles per trigger burst, every channel is granted well within it
    localparam int GAP      = NCHAN + 2;
    localparam logic [NCHAN-1:0] MASK_SOME = 'h5a;

    localparam int N_SINGLE   = 12;
    localparam int N_MULTI    = 12;
    localparam int N_MASKED   = 10;
    localparam int N_UNMASKED = 8;
    localparam int N_FILL     = FIFO_DEPTH + 4;
    localparam int N_BURSTS   = N_SINGLE + N_MULTI + N_MASKED + N_UNMASKED + 3 + N_FILL;
    localparam int DRAIN_LIMIT     = FIFO_DEPTH * 16 + 64;
    localparam int WATCHDOG_CYCLES = 2 * (N_BURSTS * GAP + 4 * (LATENCY + 4 + DRAIN_LIMIT) + 256);

    logic                       sysclk_i;
    logic                       runrst_i;
    logic [NCHAN*WB-1:0]        trig_word_i;
    logic                       trig_valid_i;
    logic [NCHAN-1:0]           trigmask_i;
    logic                       trigmask_update_i;
    trig_event_pkg::cfg_t       latency_i;
    trig_event_pkg::cfg_t       offset_i;
    trig_event_pkg::cfg_t       holdoff_i;
    trig_event_pkg::cfg_t       prescale_i;
    logic                       photo_en_i;
    logic                       evt_ack_i;
    trig_word_pkg::taddr_t      time_addr_o;
    logic [NCHAN-1:0]           scal_o;
    logic                       evt_req_o;
    trig_event_pkg::event_t     evt_data_o;
    logic                       photoshutter_o;
    logic                       overflow_o;

    // reference model state
    logic [NCHAN-1:0]           slot [2**AB] = '{default: '0};
    trig_event_pkg::event_t     exp_q [$];
    logic [NCHAN-1:0]           mask_now = '1;
    int                         scal_exp [NCHAN] = '{default: 0};
    int                         scal_cnt [NCHAN] = '{default: 0};
    int                         tcount = 0;
    int                         last_acc = -1000;
    int                         accepted = 0;
    int                         blocked = 0;
    int                         consumed = 0;
    int                         photo_cnt = 0;
    int                         drops = 0;
    int                         errors = 0;
    logic                       overfilled = 1'b0;
    logic                       stall = 1'b0;
    logic                       req_d = 1'b0;
    logic                       ack_d = 1'b0;
    logic [31:0]                lfsr = 32'h9f09_d466;

    trig_process_top #(.NCHAN(NCHAN), .FIFO_DEPTH(FIFO_DEPTH)) i_dut (
        .sysclk_i          (sysclk_i),
        .runrst_i          (runrst_i),
        .trig_word_i       (trig_word_i),
        .trig_valid_i      (trig_valid_i),
        .trigmask_i        (trigmask_i),
        .trigmask_update_i (trigmask_update_i),
        .latency_i         (latency_i),
        .offset_i          (offset_i),
        .holdoff_i         (holdoff_i),
        .prescale_i        (prescale_i),
        .photo_en_i        (photo_en_i),
        .evt_ack_i         (evt_ack_i),
        .time_addr_o       (time_addr_o),
        .scal_o            (scal_o),
        .evt_req_o         (evt_req_o),
        .evt_data_o        (evt_data_o),
        .photoshutter_o    (photoshutter_o),
        .overflow_o        (overflow_o)
    );

    initial begin
        sysclk_i = 1'b0;
        forever #5 sysclk_i = ~sysclk_i;
    end

    // galois lfsr, one step per bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) begin
                lfsr = lfsr ^ 32'h8020_0003;
            end
            v = {v[30:0], b};
        end
        return v;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("CHECK FAILED %s got %0h expected %0h at %0t", name, got, exp, $time);
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("ERROR %s at %0t", what, $time);
    endtask

    // expected time during the current cycle, 0 right after reset release
    always @(posedge sysclk_i) begin
        if (runrst_i) begin
            tcount <= 0;
        end else begin
            tcount <= tcount + 1;
        end
    end

    // model readout of one slot, holdoff counted in read cycles
    task automatic model_read(input int idx);
        trig_word_pkg::taddr_t  ra;
        trig_word_pkg::taddr_t  shifted;
        logic [NCHAN-1:0]       bits;
        trig_event_pkg::event_t ev;
        ra       = idx[AB-1:0];
        bits     = slot[ra];
        slot[ra] = '0;
        if (bits != '0) begin
            if (idx - last_acc > HOLDOFF) begin
                shifted = ra - OFFSET;
                ev      = '0;
                ev[trig_event_pkg::EVENT_BITS-1:trig_event_pkg::MAX_CHAN] = shifted;
                ev[NCHAN-1:0] = bits;
                exp_q.push_back(ev);
                last_acc = idx;
                accepted++;
            end else begin
                blocked++;
            end
        end
    endtask

    // tcount still holds the cycle that just ended, the one the DUT read in
    always @(posedge sysclk_i) begin
        if (!runrst_i && tcount >= LATENCY) begin
            model_read(tcount - LATENCY);
        end
    end

    // per-cycle checks on settled outputs
    always @(negedge sysclk_i) begin
        if (!runrst_i) begin
            assert (time_addr_o == tcount[AB-1:0])
                else report_mismatch("time_addr_o", time_addr_o, tcount[AB-1:0]);
            for (int c = 0; c < NCHAN; c++) begin
                scal_cnt[c] += int'(scal_o[c]);
            end
            photo_cnt += int'(photoshutter_o);
            assert (!(evt_req_o && !req_d && ack_d))
                else report_problem("evt_req_o rose while evt_ack_i was still high");
            if (exp_q.size() > FIFO_DEPTH) begin
                overfilled = 1'b1;
            end
            assert (!overflow_o || overfilled)
                else report_problem("overflow_o rose although the queue was never overfilled");
        end
        req_d = evt_req_o;
        ack_d = evt_ack_i;
    end

    task automatic check_stable(input trig_event_pkg::event_t held);
        assert (!evt_req_o || evt_data_o == held)
            else report_mismatch("evt_data_o", evt_data_o, held);
    endtask

    // four-phase consumer with random ack and release delays
    initial begin : consumer
        trig_event_pkg::event_t held;
        int                     wait_cyc;
        forever begin
            @(negedge sysclk_i);
            if (evt_req_o && !stall) begin
                held = evt_data_o;
                if (exp_q.size() == 0) begin
                    report_problem("event offered while none was expected");
                end else begin
                    assert (held == exp_q[0])
                        else report_mismatch("evt_data_o", held, exp_q[0]);
                end
                wait_cyc = int'(rand_bits(2));
                repeat (wait_cyc) begin
                    @(negedge sysclk_i);
                    check_stable(held);
                end
                @(posedge sysclk_i);
                evt_ack_i <= 1'b1;
                if (exp_q.size() != 0) begin
                    void'(exp_q.pop_front());
                    consumed++;
                end
                @(negedge sysclk_i);
                while (evt_req_o) begin
                    check_stable(held);
                    @(negedge sysclk_i);
                end
                wait_cyc = int'(rand_bits(2));
                repeat (wait_cyc) @(posedge sysclk_i);
                @(posedge sysclk_i);
                evt_ack_i <= 1'b0;
            end
        end
    end

    // one trigger burst, called right after a rising edge
    task automatic fire(input logic [NCHAN-1:0] chans, input int addr);
        logic [NCHAN*WB-1:0]   bus;
        trig_word_pkg::taddr_t a;
        logic                  hi;
        logic [1:0]            lo;
        a = addr[AB-1:0];
        for (int c = 0; c < NCHAN; c++) begin
            if (chans[c]) begin
                hi = rand_bits(1);
                lo = rand_bits(2);
                bus[c*WB +: WB] = {1'b1, hi, a, lo};
                scal_exp[c]++;
            end else begin
                // noise on idle channels, flag clear
                bus[c*WB +: WB] = {1'b0, 15'(rand_bits(15))};
            end
        end
        trig_word_i  <= bus;
        trig_valid_i <= 1'b1;
        // mask bites at the write, scalers still count
        slot[a] = slot[a] | (chans & ~mask_now);
        @(posedge sysclk_i);
        trig_word_i  <= '0;
        trig_valid_i <= 1'b0;
        repeat (GAP - 1) @(posedge sysclk_i);
    endtask

    task automatic fire_random(input logic [NCHAN-1:0] chans);
        int lag;
        lag = int'(rand_bits(5)) % (LAG_MAX + 1);
        fire(chans, tcount + 1 - lag);
    endtask

    function automatic logic [NCHAN-1:0] random_set();
        logic [NCHAN-1:0] s;
        s = rand_bits(NCHAN);
        if (s == '0) begin
            s[0] = 1'b1;
        end
        return s;
    endfunction

    task automatic set_mask(input logic [NCHAN-1:0] m);
        trigmask_i        <= m;
        trigmask_update_i <= 1'b1;
        @(posedge sysclk_i);
        trigmask_update_i <= 1'b0;
        mask_now = m;
        @(posedge sysclk_i);
    endtask

    // let pending reads finish, then wait for the consumer to empty the model
    task automatic wait_queue(input int target);
        int n;
        n = 0;
        repeat (LATENCY + 4) @(posedge sysclk_i);
        @(negedge sysclk_i);
        while ((exp_q.size() != target || evt_req_o) && n < DRAIN_LIMIT) begin
            @(negedge sysclk_i);
            n++;
        end
        if (n >= DRAIN_LIMIT) begin
            report_problem("queued events were not delivered in time");
        end
        @(posedge sysclk_i);
    endtask

    initial begin : stimulus
        logic [NCHAN-1:0] one;
        int               a0;
        runrst_i          = 1'b1;
        trig_word_i       = '0;
        trig_valid_i      = 1'b0;
        trigmask_i        = '0;
        trigmask_update_i = 1'b0;
        latency_i         = LATENCY;
        offset_i          = OFFSET;
        holdoff_i         = HOLDOFF;
        prescale_i        = PRESCALE;
        photo_en_i        = 1'b1;
        evt_ack_i         = 1'b0;
        repeat (8) @(posedge sysclk_i);
        runrst_i <= 1'b0;
        @(posedge sysclk_i);
        // reset leaves every channel masked
        set_mask('0);
        repeat (LATENCY) @(posedge sysclk_i);
        for (int i = 0; i < N_SINGLE; i++) begin
            one = '0;
            one[int'(rand_bits(3)) % NCHAN] = 1'b1;
            fire_random(one);
        end
        for (int i = 0; i < N_MULTI; i++) begin
            fire_random(random_set());
        end
        // masked channels still count on scal_o
        set_mask(MASK_SOME);
        for (int i = 0; i < N_MASKED; i++) begin
            fire_random(random_set());
        end
        set_mask('0);
        for (int i = 0; i < N_UNMASKED; i++) begin
            fire_random(random_set());
        end
        wait_queue(0);
        // accepted, then blocked inside holdoff, then first slot past it
        a0 = tcount + 1 - 10;
        fire('h01, a0);
        fire('h02, a0 + 3);
        fire('h04, a0 + HOLDOFF + 1);
        wait_queue(0);
        // overfill the queue with the consumer held off
        stall = 1'b1;
        for (int i = 0; i < N_FILL; i++) begin
            one = '0;
            one[i % NCHAN] = 1'b1;
            fire(one, tcount + 1 - 3);
        end
        repeat (LATENCY + 8) @(posedge sysclk_i);
        @(negedge sysclk_i);
        drops = (exp_q.size() > FIFO_DEPTH) ? exp_q.size() - FIFO_DEPTH : 0;
        assert (overflow_o == (drops > 0))
            else report_mismatch("overflow_o", overflow_o, drops > 0);
        @(posedge sysclk_i);
        stall = 1'b0;
        wait_queue(drops);
        for (int c = 0; c < NCHAN; c++) begin
            assert (scal_cnt[c] == scal_exp[c])
                else report_mismatch("scal_o count", scal_cnt[c], scal_exp[c]);
        end
        assert (photo_cnt == accepted / (PRESCALE + 1))
            else report_mismatch("photoshutter_o count", photo_cnt, accepted / (PRESCALE + 1));
        $display("errors %0d, events %0d accepted %0d delivered %0d blocked %0d dropped",
                 errors, accepted, consumed, blocked, drops);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge sysclk_i);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== logic/trig_process_top.sv ====
`timescale 1ns/1ps

module trig_process_top #(
    parameter int NCHAN      = 8,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                                    sysclk_i,
    input  logic                                    runrst_i,
    input  logic [NCHAN*trig_word_pkg::WORD_BITS-1:0] trig_word_i,
    input  logic                                    trig_valid_i,
    input  logic [NCHAN-1:0]                        trigmask_i,
    input  logic                                    trigmask_update_i,
    input  trig_event_pkg::cfg_t                    latency_i,
    input  trig_event_pkg::cfg_t                    offset_i,
    input  trig_event_pkg::cfg_t                    holdoff_i,
    input  trig_event_pkg::cfg_t                    prescale_i,
    input  logic                                    photo_en_i,
    input  logic                                    evt_ack_i,
    output trig_word_pkg::taddr_t                   time_addr_o,
    output logic [NCHAN-1:0]                        scal_o,
    output logic                                    evt_req_o,
    output trig_event_pkg::event_t                  evt_data_o,
    output logic                                    photoshutter_o,
    output logic                                    overflow_o
);

    localparam int CHAN_BITS = (NCHAN > 1) ? $clog2(NCHAN) : 1;

    // settings latched while in reset, fixed for the run
    trig_event_pkg::cfg_t   latency_q;
    trig_event_pkg::cfg_t   offset_q;
    trig_event_pkg::cfg_t   holdoff_q;
    trig_event_pkg::cfg_t   prescale_q;
    logic                   photo_en_q;
    // mask can change at any time, set bit blocks the channel
    logic [NCHAN-1:0]       mask_q;

    logic [NCHAN-1:0]       pend;
    trig_word_pkg::taddr_t  pend_addr [NCHAN];
    logic [NCHAN-1:0]       grant;
    logic                   wr_en;
    trig_word_pkg::taddr_t  wr_addr;
    logic [CHAN_BITS-1:0]   wr_chan;
    logic                   rd_valid;
    trig_word_pkg::taddr_t  rd_addr;
    logic [NCHAN-1:0]       rd_bits;
    logic                   push;
    trig_event_pkg::event_t event_word;

    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            latency_q  <= latency_i;
            offset_q   <= offset_i;
            holdoff_q  <= holdoff_i;
            prescale_q <= prescale_i;
            photo_en_q <= photo_en_i;
        end
    end

    // everything masked out of reset until software opens it
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            mask_q <= '1;
        end else if (trigmask_update_i) begin
            mask_q <= trigmask_i;
        end
    end

    // one former per channel, each on its own slice of the word bus
    for (genvar c = 0; c < NCHAN; c++) begin : g_chan
        trig_chan_former i_former (
            .sysclk_i     (sysclk_i),
            .runrst_i     (runrst_i),
            .word_i       (trig_word_i[c*trig_word_pkg::WORD_BITS +: trig_word_pkg::WORD_BITS]),
            .word_valid_i (trig_valid_i),
            .grant_i      (grant[c]),
            .pend_o       (pend[c]),
            .pend_addr_o  (pend_addr[c]),
            .scal_o       (scal_o[c])
        );
    end

    trig_write_sequencer #(.NCHAN(NCHAN)) i_seq (
        .sysclk_i    (sysclk_i),
        .runrst_i    (runrst_i),
        .pend_i      (pend),
        .pend_addr_i (pend_addr),
        .mask_i      (mask_q),
        .grant_o     (grant),
        .wr_en_o     (wr_en),
        .wr_addr_o   (wr_addr),
        .wr_chan_o   (wr_chan)
    );

    trig_delay_mem #(.NCHAN(NCHAN)) i_mem (
        .sysclk_i    (sysclk_i),
        .runrst_i    (runrst_i),
        .latency_i   (latency_q),
        .wr_en_i     (wr_en),
        .wr_addr_i   (wr_addr),
        .wr_chan_i   (wr_chan),
        .time_addr_o (time_addr_o),
        .rd_valid_o  (rd_valid),
        .rd_addr_o   (rd_addr),
        .rd_bits_o   (rd_bits)
    );

    trig_decision #(.NCHAN(NCHAN)) i_dec (
        .sysclk_i       (sysclk_i),
        .runrst_i       (runrst_i),
        .rd_valid_i     (rd_valid),
        .rd_addr_i      (rd_addr),
        .rd_bits_i      (rd_bits),
        .offset_i       (offset_q),
        .holdoff_i      (holdoff_q),
        .prescale_i     (prescale_q),
        .photo_en_i     (photo_en_q),
        .push_o         (push),
        .event_o        (event_word),
        .photoshutter_o (photoshutter_o)
    );

    trig_event_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_fifo (
        .sysclk_i   (sysclk_i),
        .runrst_i   (runrst_i),
        .push_i     (push),
        .event_i    (event_word),
        .evt_ack_i  (evt_ack_i),
        .evt_req_o  (evt_req_o),
        .evt_data_o (evt_data_o),
        .overflow_o (overflow_o)
    );

endmodule

// ==== logic/trig_event_fifo.sv ====
`timescale 1ns/1ps

module trig_event_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                    sysclk_i,
    input  logic                    runrst_i,
    input  logic                    push_i,
    input  trig_event_pkg::event_t  event_i,
    input  logic                    evt_ack_i,
    output logic                    evt_req_o,
    output trig_event_pkg::event_t  evt_data_o,
    output logic                    overflow_o
);

    localparam int PTR_BITS = $clog2(FIFO_DEPTH);

    // handshake states
    typedef enum logic [1:0] {
        HS_IDLE,
        HS_REQ,
        HS_ACK_LOW
    } hs_state_t;

    trig_event_pkg::event_t mem_q [FIFO_DEPTH];

    // one extra bit on each pointer tells full from empty
    logic [PTR_BITS:0]      wr_ptr_q;
    logic [PTR_BITS:0]      rd_ptr_q;
    logic                   empty;
    logic                   full;
    logic                   pop;
    logic                   overflow_q;
    hs_state_t              state_q;

    assign empty = (wr_ptr_q == rd_ptr_q);
    assign full  = (wr_ptr_q[PTR_BITS] != rd_ptr_q[PTR_BITS])
                && (wr_ptr_q[PTR_BITS-1:0] == rd_ptr_q[PTR_BITS-1:0]);
    // entry leaves as req drops
    assign pop   = (state_q == HS_REQ) && evt_ack_i;

    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            overflow_q <= 1'b0;
            state_q    <= HS_IDLE;
        end else begin
            // full queue drops the event, flag sticks until reset
            if (push_i && full) begin
                overflow_q <= 1'b1;
            end else if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case (state_q)
                // req only rises with data waiting and ack back low
                HS_IDLE: begin
                    if (!empty && !evt_ack_i) begin
                        state_q <= HS_REQ;
                    end
                end
                HS_REQ: begin
                    if (evt_ack_i) begin
                        state_q <= HS_ACK_LOW;
                    end
                end
                // consumer has to release ack before the next word
                HS_ACK_LOW: begin
                    if (!evt_ack_i) begin
                        state_q <= HS_IDLE;
                    end
                end
                default: state_q <= HS_IDLE;
            endcase
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (push_i && !full) begin
            mem_q[wr_ptr_q[PTR_BITS-1:0]] <= event_i;
        end
    end

    assign evt_req_o  = (state_q == HS_REQ);
    // head entry, only moves on a pop so it is steady under req
    assign evt_data_o = mem_q[rd_ptr_q[PTR_BITS-1:0]];
    assign overflow_o = overflow_q;

endmodule

// ==== logic/trig_decision.sv ====
`timescale 1ns/1ps

module trig_decision #(
    parameter int NCHAN = 8
) (
    input  logic                    sysclk_i,
    input  logic                    runrst_i,
    input  logic                    rd_valid_i,
    input  trig_word_pkg::taddr_t   rd_addr_i,
    input  logic [NCHAN-1:0]        rd_bits_i,
    input  trig_event_pkg::cfg_t    offset_i,
    input  trig_event_pkg::cfg_t    holdoff_i,
    input  trig_event_pkg::cfg_t    prescale_i,
    input  logic                    photo_en_i,
    output logic                    push_o,
    output trig_event_pkg::event_t  event_o,
    output logic                    photoshutter_o
);

    trig_event_pkg::cfg_t                   hold_cnt_q;
    trig_event_pkg::cfg_t                   pre_cnt_q;
    logic                                   accept;
    logic                                   push_q;
    logic                                   photo_q;
    trig_event_pkg::event_t                 event_q;
    logic [trig_event_pkg::MAX_CHAN-1:0]    chan_bits;

    // any channel bit in the slot is a trigger, unless holdoff is running
    assign accept = rd_valid_i && (|rd_bits_i) && (hold_cnt_q == '0);

    // pad the channel bits up to the fixed event field
    always_comb begin
        chan_bits            = '0;
        chan_bits[NCHAN-1:0] = rd_bits_i;
    end

    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            hold_cnt_q <= '0;
            push_q     <= 1'b0;
            photo_q    <= 1'b0;
            pre_cnt_q  <= prescale_i;
        end else begin
            // holdoff blocks the next holdoff cycles after an accept
            if (accept) begin
                hold_cnt_q <= holdoff_i;
            end else if (hold_cnt_q != '0) begin
                hold_cnt_q <= hold_cnt_q - 1'b1;
            end
            push_q <= accept;
            // prescaler steps on each push, fires at zero and reloads
            photo_q <= 1'b0;
            if (!photo_en_i) begin
                pre_cnt_q <= prescale_i;
            end else if (push_q) begin
                if (pre_cnt_q == '0) begin
                    photo_q   <= 1'b1;
                    pre_cnt_q <= prescale_i;
                end else begin
                    pre_cnt_q <= pre_cnt_q - 1'b1;
                end
            end
        end
    end

    // event payload, qualified by push
    always_ff @(posedge sysclk_i) begin
        if (accept) begin
            event_q <= {rd_addr_i - offset_i[trig_word_pkg::ADDR_BITS-1:0], chan_bits};
        end
    end

    assign push_o         = push_q;
    assign event_o        = event_q;
    assign photoshutter_o = photo_q;

endmodule

// ==== logic/trig_delay_mem.sv ====
`timescale 1ns/1ps

module trig_delay_mem #(
    parameter int NCHAN = 8
) (
    input  logic                    sysclk_i,
    input  logic                    runrst_i,
    input  trig_event_pkg::cfg_t    latency_i,
    input  logic                    wr_en_i,
    input  trig_word_pkg::taddr_t   wr_addr_i,
    input  logic [(NCHAN > 1 ? $clog2(NCHAN) : 1)-1:0] wr_chan_i,
    output trig_word_pkg::taddr_t   time_addr_o,
    output logic                    rd_valid_o,
    output trig_word_pkg::taddr_t   rd_addr_o,
    output logic [NCHAN-1:0]        rd_bits_o
);

    localparam int DEPTH = 2 ** trig_word_pkg::ADDR_BITS;

    // one word per sample slot, one bit per channel
    // starts out empty, afterwards the readout keeps it clean
    logic [NCHAN-1:0]       mem_q [DEPTH] = '{default: '0};

    trig_word_pkg::taddr_t  time_q;
    trig_event_pkg::cfg_t   lat_cnt_q;
    logic                   rd_run;
    trig_word_pkg::taddr_t  rd_ptr;
    logic                   rd_valid_q;
    trig_word_pkg::taddr_t  rd_addr_q;
    logic [NCHAN-1:0]       rd_bits_q;

    // readout runs once the counter has caught up with latency
    assign rd_run = (lat_cnt_q == latency_i);
    // readout trails the time base by latency, wraps like the memory
    assign rd_ptr = time_q - latency_i[trig_word_pkg::ADDR_BITS-1:0];

    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            time_q     <= '0;
            lat_cnt_q  <= '0;
            rd_valid_q <= 1'b0;
        end else begin
            // free-running time base, modulo 2^ADDR_BITS
            time_q <= time_q + 1'b1;
            // counts alongside time_q, then parks at latency
            if (!rd_run) begin
                lat_cnt_q <= lat_cnt_q + 1'b1;
            end
            rd_valid_q <= rd_run;
        end
    end

    // read-and-clear on one port, single bit set on the other
    // write lands after the clear, so a same-slot collision keeps the new bit
    always_ff @(posedge sysclk_i) begin
        rd_bits_q <= mem_q[rd_ptr];
        rd_addr_q <= rd_ptr;
        if (rd_run) begin
            mem_q[rd_ptr] <= '0;
        end
        if (wr_en_i) begin
            mem_q[wr_addr_i][wr_chan_i] <= 1'b1;
        end
    end

    assign time_addr_o = time_q;
    assign rd_valid_o  = rd_valid_q;
    assign rd_addr_o   = rd_addr_q;
    assign rd_bits_o   = rd_bits_q;

endmodule

// ==== logic/trig_write_sequencer.sv ====
`timescale 1ns/1ps

module trig_write_sequencer #(
    parameter int NCHAN = 8
) (
    input  logic                            sysclk_i,
    input  logic                            runrst_i,
    input  logic [NCHAN-1:0]                pend_i,
    input  trig_word_pkg::taddr_t           pend_addr_i [NCHAN],
    input  logic [NCHAN-1:0]                mask_i,
    output logic [NCHAN-1:0]                grant_o,
    output logic                            wr_en_o,
    output trig_word_pkg::taddr_t           wr_addr_o,
    output logic [(NCHAN > 1 ? $clog2(NCHAN) : 1)-1:0] wr_chan_o
);

    localparam int CHAN_BITS = (NCHAN > 1) ? $clog2(NCHAN) : 1;

    // last channel granted, search starts just after it
    logic [CHAN_BITS-1:0]   last_q;
    logic [CHAN_BITS-1:0]   sel;
    logic                   any_pend;
    logic                   wr_en_q;
    trig_word_pkg::taddr_t  wr_addr_q;
    logic [CHAN_BITS-1:0]   wr_chan_q;

    // round-robin pick
    // walk offsets from high to low so the nearest pending channel wins
    always_comb begin
        int idx;
        any_pend = 1'b0;
        sel      = last_q;
        for (int k = NCHAN - 1; k >= 0; k--) begin
            idx = int'(last_q) + 1 + k;
            if (idx >= NCHAN) begin
                idx = idx - NCHAN;
            end
            if (pend_i[idx]) begin
                any_pend = 1'b1;
                sel      = CHAN_BITS'(idx);
            end
        end
        // one-hot grant, at most one per clock
        grant_o = '0;
        if (any_pend) begin
            grant_o[sel] = 1'b1;
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            // first search after reset starts at channel 0
            last_q  <= CHAN_BITS'(NCHAN - 1);
            wr_en_q <= 1'b0;
        end else begin
            if (any_pend) begin
                last_q <= sel;
            end
            // masked channel is granted and cleared, but never written
            wr_en_q <= any_pend && !mask_i[sel];
        end
    end

    // write payload, qualified by wr_en
    always_ff @(posedge sysclk_i) begin
        if (any_pend) begin
            wr_addr_q <= pend_addr_i[sel];
            wr_chan_q <= sel;
        end
    end

    assign wr_en_o   = wr_en_q;
    assign wr_addr_o = wr_addr_q;
    assign wr_chan_o = wr_chan_q;

endmodule

// ==== logic/trig_chan_former.sv ====
`timescale 1ns/1ps

module trig_chan_former (
    input  logic                        sysclk_i,
    input  logic                        runrst_i,
    input  trig_word_pkg::chan_word_t   word_i,
    input  logic                        word_valid_i,
    input  logic                        grant_i,
    output logic                        pend_o,
    output trig_word_pkg::taddr_t       pend_addr_o,
    output logic                        scal_o
);

    logic                   pend_q;
    logic                   scal_q;
    trig_word_pkg::taddr_t  addr_q;
    logic                   take;

    // only a flagged, qualified word on an idle channel is caught
    // anything flagged while pending is simply dropped
    assign take = word_valid_i && word_i[trig_word_pkg::FLAG_BIT] && !pend_q;

    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            pend_q <= 1'b0;
            scal_q <= 1'b0;
        end else begin
            // scaler sees every capture, mask is applied later at the write
            scal_q <= take;
            // grant wins, pend is still high in the grant cycle so take is 0 there
            if (grant_i) begin
                pend_q <= 1'b0;
            end else if (take) begin
                pend_q <= 1'b1;
            end
        end
    end

    // address held until the sequencer picks it up
    always_ff @(posedge sysclk_i) begin
        if (take) begin
            addr_q <= word_i[trig_word_pkg::ADDR_LSB +: trig_word_pkg::ADDR_BITS];
        end
    end

    assign pend_o      = pend_q;
    assign pend_addr_o = addr_q;
    // one-cycle pulse, lines up with the first cycle of pend_o
    assign scal_o      = scal_q;

endmodule

// ==== logic/trig_event_pkg.sv ====
package trig_event_pkg;

    // latency, offset, holdoff and prescale all share this width
    localparam int CFG_BITS = 16;

    typedef logic [CFG_BITS-1:0] cfg_t;

    // upper bound on the channel count
    // the event word always reserves this many channel bits
    localparam int MAX_CHAN = 8;

    // event = offset address on top, channel bits below
    localparam int EVENT_BITS = trig_word_pkg::ADDR_BITS + MAX_CHAN;

    // [EVENT_BITS-1:MAX_CHAN] address minus offset
    // [MAX_CHAN-1:0] channel bits, unused channels read as zero
    typedef logic [EVENT_BITS-1:0] event_t;

endpackage

// ==== logic/trig_word_pkg.sv ====
package trig_word_pkg;

    // time address width
    // 4096 sample slots in the delay memory
    localparam int ADDR_BITS = 12;

    // every trigger channel delivers one 16-bit word per valid
    localparam int WORD_BITS = 16;

    // top bit of the word marks a trigger
    localparam int FLAG_BIT = 15;

    // address field starts at bit 2
    // the two bits below it carry nothing useful
    localparam int ADDR_LSB = 2;

    // sample-time address, also the delay memory index
    typedef logic [ADDR_BITS-1:0] taddr_t;

    // raw word as it arrives from a trigger channel
    // [15] flag, [13:2] address, [1:0] ignored
    typedef logic [WORD_BITS-1:0] chan_word_t;

endpackage
